/* hdl/host_domain_pkg.sv */
`default_nettype none

package host_domain_pkg;

  // Debug request bus widths
  localparam int unsigned DMI_ADDR_W = 7;
  localparam int unsigned DMI_DATA_W = 32;

  // Request operation, value 3 is reserved
  typedef enum logic [1:0] {
    DMI_NOP   = 2'd0,
    DMI_READ  = 2'd1,
    DMI_WRITE = 2'd2
  } dmi_op_e;

  // Response code returned with every request
  typedef enum logic [1:0] {
    DMI_OK     = 2'd0,
    DMI_FAILED = 2'd2
  } dmi_resp_e;

endpackage

`default_nettype wire

/* hdl/dmi_req_if.sv */
`timescale 1ns/100ps
`default_nettype none

// One request transfer, four-phase req/ack
interface dmi_req_if
  import host_domain_pkg::*;
();

  logic                  req;
  logic                  ack;
  logic [DMI_ADDR_W-1:0] addr;
  dmi_op_e               op;
  logic [DMI_DATA_W-1:0] data;

  // Payload is valid and stable while req is high
  modport producer (
    output req,
    output addr,
    output op,
    output data,
    input  ack
  );

  modport consumer (
    input  req,
    input  addr,
    input  op,
    input  data,
    output ack
  );

endinterface

`default_nettype wire

/* hdl/dmi_req_front.sv */
`timescale 1ns/100ps
`default_nettype none

module dmi_req_front
  import host_domain_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  dmi_req_valid_i,
  output logic                  dmi_req_ready_o,
  input  logic [DMI_ADDR_W-1:0] dmi_req_addr_i,
  input  dmi_op_e               dmi_req_op_i,
  input  logic [DMI_DATA_W-1:0] dmi_req_data_i,
  dmi_req_if.producer           out_if
);

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_REQ     = 2'd1;
  localparam logic [1:0] ST_RELEASE = 2'd2;

  logic [1:0]            state_q;
  logic                  accept;
  logic [DMI_ADDR_W-1:0] addr_q;
  dmi_op_e               op_q;
  logic [DMI_DATA_W-1:0] data_q;

  // Only one request in flight, new ones wait for the full handshake
  assign dmi_req_ready_o = (state_q == ST_IDLE);
  assign accept          = dmi_req_valid_i && dmi_req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (dmi_req_valid_i) begin
            state_q <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (out_if.ack) begin
            state_q <= ST_RELEASE;
          end
        end
        // Wait for the consumer to drop ack
        ST_RELEASE: begin
          if (!out_if.ack) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= dmi_req_addr_i;
      op_q   <= dmi_req_op_i;
      data_q <= dmi_req_data_i;
    end
  end

  assign out_if.req  = (state_q == ST_REQ);
  assign out_if.addr = addr_q;
  assign out_if.op   = op_q;
  assign out_if.data = data_q;

  // Req and payload hold until the consumer acks
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_if.req && !out_if.ack |=> out_if.req && $stable(out_if.addr) &&
      $stable(out_if.op) && $stable(out_if.data));

endmodule

`default_nettype wire

/* hdl/dmi_req_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module dmi_req_queue
  import host_domain_pkg::*;
#(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  dmi_req_if.consumer in_if,
  dmi_req_if.producer out_if
);

  localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);

  logic [DMI_ADDR_W-1:0] addr_mem [QUEUE_DEPTH];
  dmi_op_e               op_mem   [QUEUE_DEPTH];
  logic [DMI_DATA_W-1:0] data_mem [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             in_ack_q;
  logic             out_req_q;
  logic             full;
  logic             push;
  logic             pop;

  assign full = (count_q == (PTR_W + 1)'(QUEUE_DEPTH));

  // Take a new entry once per req phase, only with room left
  assign push = in_if.req && !in_ack_q && !full;
  assign pop  = out_req_q && out_if.ack;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_ack_q  <= 1'b0;
      out_req_q <= 1'b0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
    end else begin
      if (push) begin
        in_ack_q <= 1'b1;
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end else if (!in_if.req) begin
        in_ack_q <= 1'b0;
      end

      // Next head goes out only after the consumer released ack
      if (pop) begin
        out_req_q <= 1'b0;
        rd_ptr_q  <= rd_ptr_q + 1'b1;
      end else if (count_q != '0 && !out_if.ack && !out_req_q) begin
        out_req_q <= 1'b1;
      end

      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      addr_mem[wr_ptr_q] <= in_if.addr;
      op_mem[wr_ptr_q]   <= in_if.op;
      data_mem[wr_ptr_q] <= in_if.data;
    end
  end

  assign in_if.ack   = in_ack_q;
  assign out_if.req  = out_req_q;
  assign out_if.addr = addr_mem[rd_ptr_q];
  assign out_if.op   = op_mem[rd_ptr_q];
  assign out_if.data = data_mem[rd_ptr_q];

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(in_ack_q) |-> $past(count_q) < QUEUE_DEPTH);

  // Consumer ack must only complete a transfer backed by an entry
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_if.req && out_if.ack |-> count_q != '0);

endmodule

`default_nettype wire

/* hdl/l2_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module l2_bank
  import host_domain_pkg::*;
#(
  parameter int unsigned NUM_WORDS = 64
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  dmi_req_if.consumer           in_if,
  output logic                  dmi_resp_valid_o,
  output dmi_resp_e             dmi_resp_resp_o,
  output logic [DMI_DATA_W-1:0] dmi_resp_data_o,
  input  logic                  dmi_resp_ready_i
);

  localparam int unsigned IDX_W = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;

  logic [DMI_DATA_W-1:0] mem_q [NUM_WORDS];
  logic [IDX_W-1:0]      idx;
  logic                  addr_ok;
  logic                  slot_free;
  logic                  take;
  logic                  wr_en;
  logic                  ack_q;
  logic                  resp_valid_q;
  dmi_resp_e             resp_d;
  dmi_resp_e             resp_q;
  logic [DMI_DATA_W-1:0] rdata_d;
  logic [DMI_DATA_W-1:0] rdata_q;

  assign idx     = in_if.addr[IDX_W-1:0];
  assign addr_ok = 32'(in_if.addr) < NUM_WORDS;

  // Slot frees on the same edge the host takes the response
  assign slot_free = !resp_valid_q || dmi_resp_ready_i;
  assign take      = in_if.req && !ack_q && slot_free;
  assign wr_en     = take && addr_ok && (in_if.op == DMI_WRITE);

  always_comb begin
    resp_d  = DMI_OK;
    rdata_d = '0;
    if (!addr_ok) begin
      resp_d = DMI_FAILED;
    end else begin
      case (in_if.op)
        DMI_READ:           rdata_d = mem_q[idx];
        DMI_WRITE, DMI_NOP: rdata_d = '0;
        // Reserved encoding
        default:            resp_d = DMI_FAILED;
      endcase
    end
  end

  // Bank comes out of reset cleared
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en) begin
      mem_q[idx] <= in_if.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q        <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      if (take) begin
        ack_q <= 1'b1;
      end else if (!in_if.req) begin
        ack_q <= 1'b0;
      end

      if (take) begin
        resp_valid_q <= 1'b1;
      end else if (dmi_resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      resp_q  <= resp_d;
      rdata_q <= rdata_d;
    end
  end

  assign in_if.ack        = ack_q;
  assign dmi_resp_valid_o = resp_valid_q;
  assign dmi_resp_resp_o  = resp_q;
  assign dmi_resp_data_o  = rdata_q;

  // ack never rises without a pending req
  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(in_if.ack) |-> $past(in_if.req));

endmodule

`default_nettype wire

/* hdl/host_domain.sv */
`timescale 1ns/100ps
`default_nettype none

module host_domain
  import host_domain_pkg::*;
#(
  parameter int unsigned NUM_WORDS   = 64,
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Debug request port
  input  logic                  dmi_req_valid_i,
  output logic                  dmi_req_ready_o,
  input  logic [DMI_ADDR_W-1:0] dmi_req_addr_i,
  input  dmi_op_e               dmi_req_op_i,
  input  logic [DMI_DATA_W-1:0] dmi_req_data_i,

  // Response port
  output logic                  dmi_resp_valid_o,
  input  logic                  dmi_resp_ready_i,
  output dmi_resp_e             dmi_resp_resp_o,
  output logic [DMI_DATA_W-1:0] dmi_resp_data_o
);

  dmi_req_if front_to_queue ();
  dmi_req_if queue_to_bank ();

  dmi_req_front i_dmi_req_front (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .dmi_req_valid_i ( dmi_req_valid_i ),
    .dmi_req_ready_o ( dmi_req_ready_o ),
    .dmi_req_addr_i  ( dmi_req_addr_i  ),
    .dmi_req_op_i    ( dmi_req_op_i    ),
    .dmi_req_data_i  ( dmi_req_data_i  ),
    .out_if          ( front_to_queue  )
  );

  dmi_req_queue #(
    .QUEUE_DEPTH ( QUEUE_DEPTH )
  ) i_dmi_req_queue (
    .clk_i   ( clk_i          ),
    .rst_n_i ( rst_n_i        ),
    .in_if   ( front_to_queue ),
    .out_if  ( queue_to_bank  )
  );

  l2_bank #(
    .NUM_WORDS ( NUM_WORDS )
  ) i_l2_bank (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .in_if            ( queue_to_bank    ),
    .dmi_resp_valid_o ( dmi_resp_valid_o ),
    .dmi_resp_resp_o  ( dmi_resp_resp_o  ),
    .dmi_resp_data_o  ( dmi_resp_data_o  ),
    .dmi_resp_ready_i ( dmi_resp_ready_i )
  );

endmodule

`default_nettype wire

/* test/host_domain_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module host_domain_checker
  import host_domain_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  dmi_resp_valid_i,
  input  logic                  dmi_resp_ready_i,
  input  dmi_resp_e             dmi_resp_resp_i,
  input  logic [DMI_DATA_W-1:0] dmi_resp_data_i,
  input  logic                  exp_push_i,
  input  dmi_resp_e             exp_resp_i,
  input  logic [DMI_DATA_W-1:0] exp_data_i,
  output int                    pass_count_o,
  output int                    fail_count_o,
  output int                    pending_o
);

  // Expectations in request order
  dmi_resp_e             resp_fifo [$];
  logic [DMI_DATA_W-1:0] data_fifo [$];
  dmi_resp_e             want_resp;
  logic [DMI_DATA_W-1:0] want_data;
  logic                  match;
  int                    rsp_num;

  initial begin
    pass_count_o = 0;
    fail_count_o = 0;
    pending_o    = 0;
    rsp_num      = 0;
  end

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (exp_push_i) begin
        resp_fifo.push_back(exp_resp_i);
        data_fifo.push_back(exp_data_i);
      end
      if (dmi_resp_valid_i && dmi_resp_ready_i) begin
        rsp_num = rsp_num + 1;
        if (resp_fifo.size() == 0) begin
          $display("Response %0d arrived with no request waiting for it", rsp_num);
          fail_count_o = fail_count_o + 1;
        end else begin
          want_resp = resp_fifo.pop_front();
          want_data = data_fifo.pop_front();
          match     = 1'b1;
          if (dmi_resp_resp_i !== want_resp) begin
            $display("Mismatch dmi_resp_resp_o: expected %h, got %h",
                     want_resp, dmi_resp_resp_i);
            match = 1'b0;
          end
          if (dmi_resp_data_i !== want_data) begin
            $display("Mismatch dmi_resp_data_o: expected %h, got %h",
                     want_data, dmi_resp_data_i);
            match = 1'b0;
          end
          if (match) begin
            $display("Response %0d: PASS resp=%h data=%h", rsp_num,
                     dmi_resp_resp_i, dmi_resp_data_i);
            pass_count_o = pass_count_o + 1;
          end else begin
            $display("Response %0d: FAIL", rsp_num);
            fail_count_o = fail_count_o + 1;
          end
        end
      end
      pending_o = resp_fifo.size();
    end
  end

endmodule

`default_nettype wire

/* test/tb_host_domain.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_host_domain
  import host_domain_pkg::*;
();

  localparam int unsigned NUM_WORDS   = 64;
  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int NUM_ENTRIES  = 28;
  localparam int MAX_CYCLES   = NUM_ENTRIES * 40 + 200;
  localparam int STALL_CYCLES = 60;
  // Longer than any normal front handshake
  localparam int FILL_WAIT    = 10;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  dmi_req_valid_i;
  logic                  dmi_req_ready_o;
  logic [DMI_ADDR_W-1:0] dmi_req_addr_i;
  dmi_op_e               dmi_req_op_i;
  logic [DMI_DATA_W-1:0] dmi_req_data_i;
  logic                  dmi_resp_valid_o;
  logic                  dmi_resp_ready_i;
  dmi_resp_e             dmi_resp_resp_o;
  logic [DMI_DATA_W-1:0] dmi_resp_data_o;

  logic                  exp_push;
  dmi_resp_e             exp_resp;
  logic [DMI_DATA_W-1:0] exp_data;
  int                    pass_cnt;
  int                    fail_cnt;
  int                    pending;

  // Stimulus table, one request per row
  logic [1:0]            tbl_op    [NUM_ENTRIES];
  logic [DMI_ADDR_W-1:0] tbl_addr  [NUM_ENTRIES];
  logic [DMI_DATA_W-1:0] tbl_data  [NUM_ENTRIES];
  dmi_resp_e             tbl_resp  [NUM_ENTRIES];
  logic [DMI_DATA_W-1:0] tbl_rdata [NUM_ENTRIES];
  logic                  tbl_stall [NUM_ENTRIES];

  int n_rows;
  int seed;
  int cycle_cnt;
  int stall_left;
  int wait_run;
  int max_wait;
  int tb_pass;
  int tb_fails;

  host_domain #(
    .NUM_WORDS   ( NUM_WORDS   ),
    .QUEUE_DEPTH ( QUEUE_DEPTH )
  ) u_host_domain (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .dmi_req_valid_i  ( dmi_req_valid_i  ),
    .dmi_req_ready_o  ( dmi_req_ready_o  ),
    .dmi_req_addr_i   ( dmi_req_addr_i   ),
    .dmi_req_op_i     ( dmi_req_op_i     ),
    .dmi_req_data_i   ( dmi_req_data_i   ),
    .dmi_resp_valid_o ( dmi_resp_valid_o ),
    .dmi_resp_ready_i ( dmi_resp_ready_i ),
    .dmi_resp_resp_o  ( dmi_resp_resp_o  ),
    .dmi_resp_data_o  ( dmi_resp_data_o  )
  );

  host_domain_checker u_checker (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .dmi_resp_valid_i ( dmi_resp_valid_o ),
    .dmi_resp_ready_i ( dmi_resp_ready_i ),
    .dmi_resp_resp_i  ( dmi_resp_resp_o  ),
    .dmi_resp_data_i  ( dmi_resp_data_o  ),
    .exp_push_i       ( exp_push         ),
    .exp_resp_i       ( exp_resp         ),
    .exp_data_i       ( exp_data         ),
    .pass_count_o     ( pass_cnt         ),
    .fail_count_o     ( fail_cnt         ),
    .pending_o        ( pending          )
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  task automatic add_row(input logic [1:0] op, input logic [DMI_ADDR_W-1:0] addr,
                         input logic [DMI_DATA_W-1:0] data, input dmi_resp_e resp,
                         input logic [DMI_DATA_W-1:0] rdata, input logic stall);
    tbl_op[n_rows]    = op;
    tbl_addr[n_rows]  = addr;
    tbl_data[n_rows]  = data;
    tbl_resp[n_rows]  = resp;
    tbl_rdata[n_rows] = rdata;
    tbl_stall[n_rows] = stall;
    n_rows = n_rows + 1;
  endtask

  task automatic build_table();
    logic [DMI_DATA_W-1:0] rnd [8];
    for (int k = 0; k < 8; k++) begin
      rnd[k] = $random(seed);
    end
    add_row(DMI_READ,  7'd5,   32'h0,        DMI_OK,     32'h0,        1'b0);
    add_row(DMI_NOP,   7'd0,   32'h0,        DMI_OK,     32'h0,        1'b0);
    add_row(DMI_WRITE, 7'd3,   32'h12345678, DMI_OK,     32'h0,        1'b0);
    add_row(DMI_READ,  7'd3,   32'h0,        DMI_OK,     32'h12345678, 1'b0);
    add_row(DMI_WRITE, 7'd10,  rnd[0],       DMI_OK,     32'h0,        1'b0);
    add_row(DMI_READ,  7'd10,  32'h0,        DMI_OK,     rnd[0],       1'b0);
    // Out of range and reserved op leave memory alone
    add_row(DMI_WRITE, 7'd64,  32'hdeadbeef, DMI_FAILED, 32'h0,        1'b0);
    add_row(DMI_READ,  7'd64,  32'h0,        DMI_FAILED, 32'h0,        1'b0);
    add_row(2'd3,      7'd3,   32'hffffffff, DMI_FAILED, 32'h0,        1'b0);
    add_row(DMI_READ,  7'd3,   32'h0,        DMI_OK,     32'h12345678, 1'b0);
    add_row(DMI_READ,  7'd0,   32'h0,        DMI_OK,     32'h0,        1'b0);
    add_row(DMI_WRITE, 7'd127, 32'ha5a5a5a5, DMI_FAILED, 32'h0,        1'b0);
    // Burst while responses are stalled, queue must fill
    add_row(DMI_WRITE, 7'd20,  rnd[1],       DMI_OK,     32'h0,        1'b1);
    for (int k = 2; k < 7; k++) begin
      add_row(DMI_WRITE, 7'(19 + k), rnd[k], DMI_OK, 32'h0, 1'b0);
    end
    for (int k = 1; k < 7; k++) begin
      add_row(DMI_READ, 7'(19 + k), 32'h0, DMI_OK, rnd[k], 1'b0);
    end
    add_row(DMI_READ,  7'd63,  32'h0,        DMI_OK,     32'h0,        1'b0);
    add_row(DMI_WRITE, 7'd63,  rnd[7],       DMI_OK,     32'h0,        1'b0);
    add_row(DMI_READ,  7'd63,  32'h0,        DMI_OK,     rnd[7],       1'b0);
    add_row(DMI_NOP,   7'd9,   32'h55aa55aa, DMI_OK,     32'h0,        1'b0);
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic send_row(input int i);
    dmi_req_valid_i = 1'b1;
    dmi_req_addr_i  = tbl_addr[i];
    dmi_req_op_i    = dmi_op_e'(tbl_op[i]);
    dmi_req_data_i  = tbl_data[i];
    @(negedge clk_i);
    while (!dmi_req_ready_o) begin
      @(negedge clk_i);
    end
    exp_push = 1'b1;
    exp_resp = tbl_resp[i];
    exp_data = tbl_rdata[i];
    if (tbl_stall[i]) begin
      stall_left = STALL_CYCLES;
    end
    @(posedge clk_i);
    #1;
    exp_push = 1'b0;
  endtask

  task automatic check_reset_state();
    logic ok;
    ok = 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      if (dmi_resp_valid_o !== 1'b0) begin
        $display("Mismatch dmi_resp_valid_o: expected 0, got %h", dmi_resp_valid_o);
        ok = 1'b0;
      end
      if (dmi_req_ready_o !== 1'b1) begin
        $display("Mismatch dmi_req_ready_o: expected 1, got %h", dmi_req_ready_o);
        ok = 1'b0;
      end
    end
    if (ok) begin
      $display("Reset state: PASS");
      tb_pass = tb_pass + 1;
    end else begin
      $display("Reset state: FAIL");
      tb_fails = tb_fails + 1;
    end
  endtask

  // Response back-pressure, forced low during a stall
  always @(posedge clk_i) begin
    #1;
    if (stall_left > 0) begin
      dmi_resp_ready_i = 1'b0;
      stall_left = stall_left - 1;
    end else if (rst_n_i) begin
      dmi_resp_ready_i = (($random(seed) & 3) != 0);
    end
  end

  // Longest run of a pending request held off by the front
  always @(negedge clk_i) begin
    if (dmi_req_valid_i && !dmi_req_ready_o) begin
      wait_run = wait_run + 1;
      if (wait_run > max_wait) begin
        max_wait = wait_run;
      end
    end else begin
      wait_run = 0;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    seed             = 25;
    n_rows           = 0;
    cycle_cnt        = 0;
    stall_left       = 0;
    wait_run         = 0;
    max_wait         = 0;
    tb_pass          = 0;
    tb_fails         = 0;
    rst_n_i          = 1'b0;
    dmi_req_valid_i  = 1'b0;
    dmi_req_addr_i   = '0;
    dmi_req_op_i     = DMI_NOP;
    dmi_req_data_i   = '0;
    dmi_resp_ready_i = 1'b0;
    exp_push         = 1'b0;
    exp_resp         = DMI_OK;
    exp_data         = '0;
    build_table();
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check_reset_state();
    @(posedge clk_i);
    #1;
    for (int i = 0; i < n_rows; i++) begin
      send_row(i);
    end
    dmi_req_valid_i = 1'b0;
    @(negedge clk_i);
    while (pending != 0) begin
      @(negedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    if (max_wait >= FILL_WAIT) begin
      $display("Queue fill: PASS ready held low %0d cycles then recovered", max_wait);
      tb_pass = tb_pass + 1;
    end else begin
      $display("Queue fill: FAIL ready never stayed low long enough, longest %0d", max_wait);
      tb_fails = tb_fails + 1;
    end
    $display("Tests done: %0d passed, %0d failed", pass_cnt + tb_pass,
             fail_cnt + pending + tb_fails);
    if (fail_cnt + pending + tb_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* host_domain.f */
hdl/host_domain_pkg.sv
hdl/dmi_req_if.sv
hdl/dmi_req_front.sv
hdl/dmi_req_queue.sv
hdl/l2_bank.sv
hdl/host_domain.sv
test/host_domain_checker.sv
test/tb_host_domain.sv

/* Bender.yml */
package:
  name: host_domain

sources:
  - hdl/host_domain_pkg.sv
  - hdl/dmi_req_if.sv
  - hdl/dmi_req_front.sv
  - hdl/dmi_req_queue.sv
  - hdl/l2_bank.sv
  - hdl/host_domain.sv
  - target: test
    files:
      - test/host_domain_checker.sv
      - test/tb_host_domain.sv
